// ==== ext_harness_top.sv ====
/*
 * External harness top: slow-memory path, register peripherals and the
 * power-switch emulator around the MCU's external bus
 */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module ext_harness_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  harness_pkg::obi_req_t  mem_req_i,
  output harness_pkg::obi_resp_t mem_resp_o,
  input  harness_pkg::reg_req_t  reg_req_i,
  output harness_pkg::reg_rsp_t  reg_rsp_o,
  input  logic                   gpio_i,
  output logic                   gpio_o,
  input  logic [`NUM_INTR-2:0]   ext_irq_i,
  output harness_pkg::intr_t     intr_vector_o,
  output harness_pkg::data_t     exit_value_o,
  output logic                   exit_valid_o,
  input  harness_pkg::domain_t   switch_n_i,
  output harness_pkg::domain_t   switch_ack_n_o
);

  harness_pkg::obi_req_t  fifo_mem_req;
  harness_pkg::obi_resp_t fifo_mem_resp;
  harness_pkg::reg_req_t  gpio_req;
  harness_pkg::reg_rsp_t  gpio_rsp;
  harness_pkg::reg_req_t  simctrl_req;
  harness_pkg::reg_rsp_t  simctrl_rsp;
  harness_pkg::intr_t     irq_raw;
  logic                   gpio_irq;

  // GPIO counter in bit 0, external lines above it
  assign irq_raw = {ext_irq_i, gpio_irq};

  // Extra FIFO stage makes the slow memory slower still
  obi_fifo i_obi_fifo (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .producer_req_i (mem_req_i),
    .producer_resp_o(mem_resp_o),
    .consumer_req_o (fifo_mem_req),
    .consumer_resp_i(fifo_mem_resp)
  );

  slow_memory i_slow_memory (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (fifo_mem_req),
    .resp_o(fifo_mem_resp)
  );

  periph_reg_demux i_periph_reg_demux (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (reg_req_i),
    .rsp_o        (reg_rsp_o),
    .gpio_req_o   (gpio_req),
    .simctrl_req_o(simctrl_req),
    .gpio_rsp_i   (gpio_rsp),
    .simctrl_rsp_i(simctrl_rsp)
  );

  gpio_counter #(
    .CNT_MAX(`GPIO_CNT_MAX)
  ) i_gpio_counter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .reg_req_i(gpio_req),
    .reg_rsp_o(gpio_rsp),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .irq_o    (gpio_irq)
  );

  sim_ctrl_regs i_sim_ctrl_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .reg_req_i    (simctrl_req),
    .reg_rsp_o    (simctrl_rsp),
    .irq_src_i    (irq_raw),
    .intr_vector_o(intr_vector_o),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

  switch_ack_delay i_switch_ack_delay (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .switch_n_i(switch_n_i),
    .ack_n_o   (switch_ack_n_o)
  );

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
harness_pkg.sv
obi_fifo.sv
slow_memory.sv
periph_reg_demux.sv
gpio_counter.sv
sim_ctrl_regs.sv
switch_ack_delay.sv
ext_harness_top.sv
tb_ext_harness.sv

// ==== gpio_counter.sv ====
/*
 * GPIO edge counter: counts rising edges on gpio_i and raises an
 * interrupt and toggles gpio_o once the limit is reached
 */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module gpio_counter #(
  parameter int unsigned CNT_MAX = `GPIO_CNT_MAX
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  harness_pkg::reg_req_t reg_req_i,
  output harness_pkg::reg_rsp_t reg_rsp_o,
  input  logic                  gpio_i,
  output logic                  gpio_o,
  output logic                  irq_o
);

  harness_pkg::data_t cnt_q;
  logic gpio_sync_q;
  logic gpio_prev_q;
  logic gpio_out_q;
  logic irq_q;
  logic rise;
  logic wr;

  assign rise = gpio_sync_q && !gpio_prev_q;
  assign wr   = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_sync_q <= 1'b0;
      gpio_prev_q <= 1'b0;
      gpio_out_q  <= 1'b0;
      irq_q       <= 1'b0;
      cnt_q       <= '0;
    end else begin
      gpio_sync_q <= gpio_i;
      gpio_prev_q <= gpio_sync_q;
      if (wr) begin
        cnt_q <= '0;
        irq_q <= 1'b0;
      end else if (rise && !irq_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Last edge before the limit, stop here
        if (cnt_q == harness_pkg::data_t'(CNT_MAX - 1)) begin
          irq_q      <= 1'b1;
          gpio_out_q <= !gpio_out_q;
        end
      end
    end
  end

  assign reg_rsp_o.ready = 1'b1;
  assign reg_rsp_o.error = 1'b0;
  assign reg_rsp_o.rdata = (reg_req_i.addr == `REG_COUNT) ? cnt_q : '0;

  assign gpio_o = gpio_out_q;
  assign irq_o  = irq_q;

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= harness_pkg::data_t'(CNT_MAX));

endmodule

`default_nettype wire

// ==== harness_defines.svh ====
/*
 * External harness constants: bus widths, memory geometry, latencies and
 * the register map of the two external peripherals
 */
`ifndef HARNESS_DEFINES_SVH
`define HARNESS_DEFINES_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32

// Slow memory behind the OBI port
`define MEM_WORDS 1024
`define MEM_IDX_W 10
`define SLOW_MEM_LATENCY 4
`define OBI_FIFO_DEPTH 2

// Power-switch emulation
`define SWITCH_ACK_LATENCY 15
`define NUM_DOMAINS 4

// Interrupts and GPIO counter
`define NUM_INTR 4
`define GPIO_CNT_MAX 8

// Register-bus address map
`define GPIO_BASE 32'h0000_0000
`define SIMCTRL_BASE 32'h0000_1000
`define PERIPH_SIZE 32'h0000_1000

// Register offsets inside a region
`define REG_COUNT 32'h0000_0000
`define REG_EXIT 32'h0000_0000
`define REG_IRQ_MASK 32'h0000_0004

`endif

// ==== harness_pkg.sv ====
/*
 * Harness package: bus, interrupt and power-domain types shared by the
 * memory path, the register path and their testbench
 */
`default_nettype none

`include "harness_defines.svh"

package harness_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [3:0] be_t;
  typedef logic [`MEM_IDX_W-1:0] mem_idx_t;
  typedef logic [`NUM_INTR-1:0] intr_t;
  typedef logic [`NUM_DOMAINS-1:0] domain_t;

  // OBI request and response
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_resp_t;

  // Single-cycle register bus
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    logic  error;
    data_t rdata;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    PERIPH_GPIO,
    PERIPH_SIMCTRL,
    PERIPH_NONE
  } periph_sel_e;

endpackage

`default_nettype wire

// ==== harness_vectors.txt ====
# columns: kind address data expected, all hex (MW puts byte enables in expected)
# kinds: MW MR ML MD memory, RW RR RX register, GE GO gpio, IV irq, EX exit, SW switch
MW 00000000 11223344 f
MW 00000000 aabbccdd 5
MW 00000004 12345678 f
MW 00000004 cafef00d 3
MW 00000008 ffffffff f
MW 00000008 00000000 8
MR 00000000 0 11bb33dd
MR 00000004 0 1234f00d
MR 00000008 0 00ffffff
MD 0 0 0
ML 00000100 0 0
ML 00000ffc 0 0
MD 0 0 0
RX 00002000 0 0
RX 80000000 0 0
RW 00001004 f 0
RR 00001004 0 f
GE 0 5 0
RR 00000000 0 5
GO 0 0 0
GE 0 3 0
RR 00000000 0 8
IV 0 0 1
GO 0 0 1
GE 0 2 0
RR 00000000 0 8
RW 00000000 0 0
RR 00000000 0 0
IV 0 0 0
IV 0 5 a
RW 00001004 5 0
IV 0 7 4
RR 00001004 0 5
RW 00001000 deadbeef 0
EX 0 0 deadbeef
RR 00001000 0 deadbeef
SW 0 e 0
SW 0 0 0
SW 0 f 0

// ==== obi_fifo.sv ====
/*
 * OBI request FIFO: buffers requests in front of the slow memory,
 * responses go straight back to the producer
 */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module obi_fifo (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  harness_pkg::obi_req_t  producer_req_i,
  output harness_pkg::obi_resp_t producer_resp_o,
  output harness_pkg::obi_req_t  consumer_req_o,
  input  harness_pkg::obi_resp_t consumer_resp_i
);

  localparam int unsigned PTR_W = $clog2(`OBI_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(`OBI_FIFO_DEPTH + 1);

  harness_pkg::obi_req_t entry_q [`OBI_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic full;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`OBI_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count_q == CNT_W'(`OBI_FIFO_DEPTH));
  assign push = producer_req_i.req && !full;
  assign pop  = consumer_req_o.req && consumer_resp_i.gnt;

  assign producer_resp_o.gnt    = push;
  assign producer_resp_o.rvalid = consumer_resp_i.rvalid;
  assign producer_resp_o.rdata  = consumer_resp_i.rdata;

  // Oldest entry goes out first
  always_comb begin
    consumer_req_o     = entry_q[rd_ptr_q];
    consumer_req_o.req = (count_q != '0);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= producer_req_i;
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= CNT_W'(`OBI_FIFO_DEPTH));

  // A full buffer only drains, it never takes another push
  a_full_no_push: assert property (@(posedge clk_i) disable iff (rst_i)
    full && !pop |=> full);

endmodule

`default_nettype wire

// ==== periph_reg_demux.sv ====
/*
 * Register-bus demux: decodes the address into one of two peripheral
 * regions and answers unmapped accesses with an error
 */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module periph_reg_demux (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  harness_pkg::reg_req_t req_i,
  output harness_pkg::reg_rsp_t rsp_o,
  output harness_pkg::reg_req_t gpio_req_o,
  output harness_pkg::reg_req_t simctrl_req_o,
  input  harness_pkg::reg_rsp_t gpio_rsp_i,
  input  harness_pkg::reg_rsp_t simctrl_rsp_i
);

  harness_pkg::periph_sel_e sel;
  harness_pkg::addr_t gpio_off;
  harness_pkg::addr_t simctrl_off;

  // Offsets inside each region, also used for the range check
  assign gpio_off    = req_i.addr - `GPIO_BASE;
  assign simctrl_off = req_i.addr - `SIMCTRL_BASE;

  always_comb begin
    if (gpio_off < `PERIPH_SIZE) begin
      sel = harness_pkg::PERIPH_GPIO;
    end else if (simctrl_off < `PERIPH_SIZE) begin
      sel = harness_pkg::PERIPH_SIMCTRL;
    end else begin
      sel = harness_pkg::PERIPH_NONE;
    end
  end

  always_comb begin
    gpio_req_o          = req_i;
    gpio_req_o.valid    = req_i.valid && (sel == harness_pkg::PERIPH_GPIO);
    gpio_req_o.addr     = gpio_off;
    simctrl_req_o       = req_i;
    simctrl_req_o.valid = req_i.valid && (sel == harness_pkg::PERIPH_SIMCTRL);
    simctrl_req_o.addr  = simctrl_off;
  end

  always_comb begin
    case (sel)
      harness_pkg::PERIPH_GPIO:    rsp_o = gpio_rsp_i;
      harness_pkg::PERIPH_SIMCTRL: rsp_o = simctrl_rsp_i;
      default: begin
        rsp_o.ready = 1'b1;
        rsp_o.error = 1'b1;
        rsp_o.rdata = '0;
      end
    endcase
  end

  a_one_target: assert property (@(posedge clk_i) disable iff (rst_i)
    !(gpio_req_o.valid && simctrl_req_o.valid));

  // Peripherals behind a mapped region never flag an error
  a_mapped_ok: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.valid && sel != harness_pkg::PERIPH_NONE |-> !rsp_o.error);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the external harness testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_ext_harness \
  -o tb_ext_harness && ./obj_dir/tb_ext_harness > sim.log 2>&1 || true
cat sim.log 2>/dev/null || true
grep -q "^ALL CHECKS PASSED" sim.log 2>/dev/null && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

// ==== sim_ctrl_regs.sv ====
/*
 * Simulation control registers holding the sticky exit value and the
 * mask applied to the external interrupt vector
 */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module sim_ctrl_regs (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  harness_pkg::reg_req_t reg_req_i,
  output harness_pkg::reg_rsp_t reg_rsp_o,
  input  harness_pkg::intr_t    irq_src_i,
  output harness_pkg::intr_t    intr_vector_o,
  output harness_pkg::data_t    exit_value_o,
  output logic                  exit_valid_o
);

  harness_pkg::data_t exit_value_q;
  harness_pkg::intr_t mask_q;
  logic exit_valid_q;
  logic wr;

  assign wr = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      mask_q       <= '0;
    end else if (wr) begin
      if (reg_req_i.addr == `REG_EXIT) begin
        exit_value_q <= reg_req_i.wdata;
        exit_valid_q <= 1'b1;
      end
      if (reg_req_i.addr == `REG_IRQ_MASK) begin
        mask_q <= reg_req_i.wdata[`NUM_INTR-1:0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    if (reg_req_i.addr == `REG_EXIT) begin
      reg_rsp_o.rdata = exit_value_q;
    end else if (reg_req_i.addr == `REG_IRQ_MASK) begin
      reg_rsp_o.rdata = harness_pkg::data_t'(mask_q);
    end
  end

  assign intr_vector_o = irq_src_i & mask_q;
  assign exit_value_o  = exit_value_q;
  assign exit_valid_o  = exit_valid_q;

endmodule

`default_nettype wire

// ==== slow_memory.sv ====
/*
 * Slow memory: word-addressed RAM with byte enables, grants every request
 * and returns rvalid a fixed number of cycles after the grant
 */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module slow_memory (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  harness_pkg::obi_req_t  req_i,
  output harness_pkg::obi_resp_t resp_o
);

  localparam int unsigned LAT = `SLOW_MEM_LATENCY;
  localparam int unsigned NUM_BYTES = $bits(harness_pkg::be_t);

  harness_pkg::data_t mem_q [`MEM_WORDS];
  harness_pkg::mem_idx_t idx;
  logic gnt;

  logic [LAT-1:0] valid_q;
  harness_pkg::data_t rdata_q [LAT];

  assign gnt = req_i.req;
  // Word index sits above the byte offset
  assign idx = req_i.addr[`MEM_IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (gnt && req_i.we) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Latency pipeline, writes answer with zero
  always_ff @(posedge clk_i) begin
    rdata_q[0] <= req_i.we ? '0 : mem_q[idx];
    for (int s = 1; s < LAT; s++) begin
      rdata_q[s] <= rdata_q[s-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[LAT-2:0], gnt};
    end
  end

  assign resp_o.gnt    = gnt;
  assign resp_o.rvalid = valid_q[LAT-1];
  assign resp_o.rdata  = rdata_q[LAT-1];

  a_addr_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    gnt |-> req_i.addr < harness_pkg::addr_t'(`MEM_WORDS * NUM_BYTES));

endmodule

`default_nettype wire

// ==== switch_ack_delay.sv ====
/*
 * Power-switch emulation: each domain acknowledges its switch request
 * a fixed number of cycles later
 */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module switch_ack_delay (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  harness_pkg::domain_t switch_n_i,
  output harness_pkg::domain_t ack_n_o
);

  harness_pkg::domain_t pipe_q [`SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < `SWITCH_ACK_LATENCY; s++) begin
        pipe_q[s] <= '1;
      end
    end else begin
      pipe_q[0] <= switch_n_i;
      for (int s = 1; s < `SWITCH_ACK_LATENCY; s++) begin
        pipe_q[s] <= pipe_q[s-1];
      end
    end
  end

  assign ack_n_o = pipe_q[`SWITCH_ACK_LATENCY-1];

endmodule

`default_nettype wire

// ==== tb_ext_harness.sv ====
/*
 * Testbench for the external harness: replays operations from a vector
 * file and checks memory, register, interrupt and power-switch responses
 */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module tb_ext_harness;

  localparam int CLK_HALF   = 20;
  localparam int GNT_WAIT   = 20;
  localparam int DRAIN_WAIT = 40;

  logic                   clk_i;
  logic                   rst_i;
  harness_pkg::obi_req_t  mem_req_i;
  harness_pkg::obi_resp_t mem_resp_o;
  harness_pkg::reg_req_t  reg_req_i;
  harness_pkg::reg_rsp_t  reg_rsp_o;
  logic                   gpio_i;
  logic                   gpio_o;
  logic [`NUM_INTR-2:0]   ext_irq_i;
  harness_pkg::intr_t     intr_vector_o;
  harness_pkg::data_t     exit_value_o;
  logic                   exit_valid_o;
  harness_pkg::domain_t   switch_n_i;
  harness_pkg::domain_t   switch_ack_n_o;

  // Vector table, one entry per operation
  string              vec_kind[$];
  harness_pkg::data_t vec_addr[$];
  harness_pkg::data_t vec_data[$];
  harness_pkg::data_t vec_exp[$];
  int                 num_vec = 0;

  // Memory responses still owed, oldest first
  harness_pkg::data_t exp_q[$];
  string              name_q[$];

  logic [31:0]          lfsr_q;
  harness_pkg::domain_t switch_prev;
  int                   num_checks = 0;
  int                   value_errors = 0;
  int                   other_errors = 0;

  ext_harness_top i_ext_harness_top (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mem_req_i     (mem_req_i),
    .mem_resp_o    (mem_resp_o),
    .reg_req_i     (reg_req_i),
    .reg_rsp_o     (reg_rsp_o),
    .gpio_i        (gpio_i),
    .gpio_o        (gpio_o),
    .ext_irq_i     (ext_irq_i),
    .intr_vector_o (intr_vector_o),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o),
    .switch_n_i    (switch_n_i),
    .switch_ack_n_o(switch_ack_n_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic check_data(input string name, input harness_pkg::data_t exp,
                            input harness_pkg::data_t act);
    num_checks++;
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_intr(input string name, input harness_pkg::intr_t exp,
                            input harness_pkg::intr_t act);
    num_checks++;
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_domain(input string name, input harness_pkg::domain_t exp,
                              input harness_pkg::domain_t act);
    num_checks++;
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_rsp(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp) begin
      $display("ERROR %s error bit expected %b actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp) begin
      $display("ERROR %s expected %b actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_word(output harness_pkg::data_t word);
    word = '0;
    for (int b = 0; b < `DATA_W; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      word = {word[`DATA_W-2:0], lfsr_q[0]};
    end
  endtask

  task automatic load_vectors();
    int          fd;
    string       line;
    string       kind;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("harness_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open harness_vectors.txt");
      other_errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      // Blank lines and comments
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      if ($sscanf(line, "%s %h %h %h", kind, a, d, e) == 4) begin
        vec_kind.push_back(kind);
        vec_addr.push_back(a);
        vec_data.push_back(d);
        vec_exp.push_back(e);
      end else begin
        $display("malformed vector line: %s", line);
        other_errors++;
      end
    end
    $fclose(fd);
    if (vec_kind.size() == 0) begin
      $display("vector file holds no operations");
      other_errors++;
    end
    num_vec = vec_kind.size();
  endtask

  // Starts and ends on a falling edge, the response is owed later
  task automatic mem_access(input string name, input logic write, input harness_pkg::be_t be,
                            input harness_pkg::addr_t addr, input harness_pkg::data_t wdata,
                            input harness_pkg::data_t exp);
    int waited;
    waited = 0;
    mem_req_i.req   = 1'b1;
    mem_req_i.we    = write;
    mem_req_i.be    = be;
    mem_req_i.addr  = addr;
    mem_req_i.wdata = wdata;
    #1;
    while (!mem_resp_o.gnt && waited < GNT_WAIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (mem_resp_o.gnt) begin
      exp_q.push_back(exp);
      name_q.push_back(name);
    end else begin
      $display("%s: memory request was never granted", name);
      other_errors++;
    end
    @(negedge clk_i);
    mem_req_i = '0;
  endtask

  task automatic wait_drain(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_WAIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d memory responses never arrived", name, exp_q.size());
      other_errors++;
    end
  endtask

  task automatic reg_access(input string name, input logic write,
                            input harness_pkg::addr_t addr, input harness_pkg::data_t wdata,
                            output harness_pkg::reg_rsp_t rsp);
    reg_req_i.valid = 1'b1;
    reg_req_i.write = write;
    reg_req_i.addr  = addr;
    reg_req_i.wdata = wdata;
    #1;
    rsp = reg_rsp_o;
    if (rsp.ready !== 1'b1) begin
      $display("%s: register access not ready in its own cycle", name);
      other_errors++;
    end
    @(negedge clk_i);
    reg_req_i = '0;
  endtask

  task automatic gpio_edges(input int count);
    for (int n = 0; n < count; n++) begin
      gpio_i = 1'b1;
      repeat (2) @(negedge clk_i);
      gpio_i = 1'b0;
      repeat (2) @(negedge clk_i);
    end
    // Input synchronizer settles
    repeat (3) @(negedge clk_i);
  endtask

  task automatic switch_step(input string name, input harness_pkg::domain_t value);
    harness_pkg::domain_t old_value;
    old_value   = switch_prev;
    switch_n_i  = value;
    switch_prev = value;
    for (int k = 1; k <= `SWITCH_ACK_LATENCY; k++) begin
      @(negedge clk_i);
      check_domain(name, (k < `SWITCH_ACK_LATENCY) ? old_value : value, switch_ack_n_o);
    end
  endtask

  task automatic check_reset_state();
    #1;
    check_intr("reset intr_vector", '0, intr_vector_o);
    check_flag("reset exit_valid", 1'b0, exit_valid_o);
    check_flag("reset gpio_o", 1'b0, gpio_o);
    check_flag("reset rvalid", 1'b0, mem_resp_o.rvalid);
    check_flag("reset gnt", 1'b0, mem_resp_o.gnt);
    check_domain("reset switch ack", '1, switch_ack_n_o);
    @(negedge clk_i);
  endtask

  task automatic run_vector(input int i);
    string                 name;
    string                 kind;
    harness_pkg::reg_rsp_t rsp;
    harness_pkg::data_t    word;
    kind = vec_kind[i];
    name = $sformatf("%s %h #%0d", kind, vec_addr[i], i);
    case (kind)
      "MW": mem_access(name, 1'b1, vec_exp[i][3:0], vec_addr[i], vec_data[i], '0);
      "MR": mem_access(name, 1'b0, 4'hf, vec_addr[i], '0, vec_exp[i]);
      "ML": begin
        draw_word(word);
        mem_access(name, 1'b1, 4'hf, vec_addr[i], word, '0);
        mem_access(name, 1'b0, 4'hf, vec_addr[i], '0, word);
      end
      "MD": wait_drain(name);
      "RW": begin
        reg_access(name, 1'b1, vec_addr[i], vec_data[i], rsp);
        check_rsp(name, vec_exp[i][0], rsp.error);
      end
      "RR": begin
        reg_access(name, 1'b0, vec_addr[i], '0, rsp);
        check_rsp(name, 1'b0, rsp.error);
        check_data(name, vec_exp[i], rsp.rdata);
      end
      "RX": begin
        reg_access(name, 1'b0, vec_addr[i], '0, rsp);
        check_rsp(name, 1'b1, rsp.error);
        check_data(name, vec_exp[i], rsp.rdata);
      end
      "GE": gpio_edges(vec_data[i]);
      "GO": begin
        check_flag(name, vec_exp[i][0], gpio_o);
        @(negedge clk_i);
      end
      "IV": begin
        ext_irq_i = vec_data[i][`NUM_INTR-2:0];
        #1;
        check_intr(name, vec_exp[i][`NUM_INTR-1:0], intr_vector_o);
        @(negedge clk_i);
      end
      "EX": begin
        check_flag(name, 1'b1, exit_valid_o);
        check_data(name, vec_exp[i], exit_value_o);
        @(negedge clk_i);
      end
      "SW": switch_step(name, vec_data[i][`NUM_DOMAINS-1:0]);
      default: begin
        $display("unknown operation kind %s in vector %0d", kind, i);
        other_errors++;
      end
    endcase
  endtask

  // Every rvalid retires the oldest outstanding request
  always @(negedge clk_i) begin
    if (!rst_i && mem_resp_o.rvalid) begin
      if (exp_q.size() == 0) begin
        $display("memory rvalid arrived with no request outstanding");
        other_errors++;
      end else begin
        check_data(name_q.pop_front(), exp_q.pop_front(), mem_resp_o.rdata);
      end
    end
  end

  initial begin
    wait (num_vec > 0);
    repeat (num_vec * 40 + 200) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, operations did not finish",
             num_vec * 40 + 200);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_i       = 1'b1;
    mem_req_i   = '0;
    reg_req_i   = '0;
    gpio_i      = 1'b0;
    ext_irq_i   = '0;
    switch_n_i  = '1;
    switch_prev = '1;
    lfsr_q      = 32'h6908_2bcd;
    load_vectors();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_reset_state();
    for (int i = 0; i < num_vec; i++) begin
      run_vector(i);
    end
    wait_drain("final drain");
    $display("checks %0d, value errors %0d, other errors %0d",
             num_checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
